//--- csr_file.f
+incdir+include
hdl/csr_pkg.sv
hdl/csr_mode_ctrl.sv
hdl/csr_timer.sv
hdl/csr_except_regs.sv
hdl/csr_read_mux.sv
hdl/csr_file.sv
dv/csr_file_tb.sv

//--- dv/csr_file_tb.sv
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_file_tb;

    localparam int K_ONESHOT  = 3;
    localparam int K_PERIODIC = 2;
    localparam int RAND_ITERS = 16;
    localparam int IRQ_ITERS  = 12;
    localparam int TI_BIT     = 11;

    // per-test lengths in cycles
    localparam int LEN_RESET  = 8;
    localparam int LEN_MASKED = 3 * RAND_ITERS + 4;
    localparam int LEN_MODE   = RAND_ITERS + 6;
    localparam int LEN_TRAP   = 16;
    localparam int LEN_ECODE  = 12;
    localparam int LEN_TIMER  = (4 * K_ONESHOT + 3) + (4 * K_PERIODIC + 3)
                                + (4 * K_PERIODIC + 2) + 16;
    localparam int LEN_IRQ    = 4 * IRQ_ITERS + 4;
    localparam int CYCLE_LIMIT = 3 * (LEN_RESET + LEN_MASKED + LEN_MODE + LEN_TRAP
                                      + LEN_ECODE + LEN_TIMER + LEN_IRQ) / 2;

    logic                   clk;
    logic                   rstn;
    csr_pkg::csr_wr_t       csr_wr;
    logic [`CSR_ADDR_W-1:0] raddr;
    logic [`CSR_DATA_W-1:0] rdata;
    csr_pkg::trap_evt_t     trap;
    logic [`HW_INT_W-1:0]   hw_int;
    csr_pkg::cpu_status_t   status;
    logic                   int_cpu;
    logic                   int_idle;

    int          errors;
    int          prop_errors;
    int          cycles;
    logic [15:0] lfsr_state;

    // reference copies of the register state
    csr_pkg::crmd_t exp_crmd;
    csr_pkg::prmd_t exp_prmd;
    logic [31:0]    exp_ecfg;
    logic [31:0]    exp_era;
    logic [31:0]    exp_eentry;
    logic [5:0]     exp_ecode;
    logic [8:0]     exp_esub;
    logic [1:0]     exp_sw;
    logic           exp_ti;
    logic [12:0]    exp_is;

    csr_file dut (
        .clk      (clk),
        .rstn     (rstn),
        .csr_wr   (csr_wr),
        .raddr    (raddr),
        .rdata    (rdata),
        .trap     (trap),
        .hw_int   (hw_int),
        .status   (status),
        .int_cpu  (int_cpu),
        .int_idle (int_idle)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("sim failed");
            $finish;
        end
    end

    ////////////////////////////////////////
    // concurrent checks
    ////////////////////////////////////////

    assert property (@(posedge clk) disable iff (!rstn) $onehot(status.translate_mode))
        else begin
            $display("MISMATCH %0t: translate_mode %b not one-hot", $time,
                     status.translate_mode);
            prop_errors++;
        end

    assert property (@(posedge clk) disable iff (!rstn) (|hw_int) |-> int_idle)
        else begin
            $display("MISMATCH %0t: hw_int %h pending but int_idle low", $time, hw_int);
            prop_errors++;
        end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] apply_mask(input logic [31:0] old_w, new_w, mask);
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    function automatic csr_pkg::crmd_t crmd_after_write(input csr_pkg::crmd_t old_v,
                                                       input logic [31:0] mask, data);
        csr_pkg::crmd_t m;
        csr_pkg::crmd_t r;
        m = apply_mask(old_v, data, mask);
        r = old_v;
        r.plv  = m.plv;
        r.ie   = m.ie;
        r.datf = m.datf;
        r.datm = m.datm;
        // only a one-hot pg/da pair is taken
        if (m.pg != m.da) begin
            r.pg = m.pg;
            r.da = m.da;
        end
        return r;
    endfunction

    function automatic logic [31:0] estat_word(input logic [5:0] ecode, input logic [8:0] esub,
                                               input logic [12:0] is_v);
        csr_pkg::estat_t e;
        e = '0;
        e.ecode    = ecode;
        e.esubcode = esub;
        e.is       = is_v;
        return e;
    endfunction

    task automatic rand_bits(input int nbits, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
            else begin
                $display("MISMATCH %0t: %s is %h, expected %h", $time, what, got, exp);
                errors++;
            end
    endtask

    task automatic csr_write(input logic [13:0] addr, input logic [31:0] mask, data);
        csr_wr.en       = 1'b1;
        csr_wr.addr     = addr;
        csr_wr.mask     = mask;
        csr_wr.data.raw = data;
        next_cycle();
        csr_wr.en = 1'b0;
    endtask

    // rdata is combinational from raddr
    task automatic csr_read(input logic [13:0] addr, output logic [31:0] data);
        raddr = addr;
        #0.25;
        data = rdata;
    endtask

    task automatic expect_csr(input string what, input logic [13:0] addr, input logic [31:0] exp);
        logic [31:0] v;
        csr_read(addr, v);
        check_word(what, v, exp);
    endtask

    task automatic crmd_write_check(input logic [31:0] mask, data);
        csr_write(`CSR_CRMD, mask, data);
        exp_crmd = crmd_after_write(exp_crmd, mask, data);
        expect_csr("crmd after write", `CSR_CRMD, exp_crmd);
        check_word("translate_mode", 32'(status.translate_mode), 32'({exp_crmd.pg, exp_crmd.da}));
        check_word("status mode fields", 32'({status.plv, status.ie, status.datf, status.datm}),
                   32'({exp_crmd.plv, exp_crmd.ie, exp_crmd.datf, exp_crmd.datm}));
    endtask

    task automatic do_store();
        trap.store_state = 1'b1;
        next_cycle();
        trap.store_state = 1'b0;
    endtask

    task automatic do_restore();
        trap.restore_state = 1'b1;
        next_cycle();
        trap.restore_state = 1'b0;
        exp_crmd.plv = exp_prmd.pplv;
        exp_crmd.ie  = exp_prmd.pie;
        expect_csr("crmd after restore", `CSR_CRMD, exp_crmd);
    endtask

    task automatic expect_stored();
        exp_prmd.pplv = exp_crmd.plv;
        exp_prmd.pie  = exp_crmd.ie;
        exp_crmd.plv  = 2'b00;
        exp_crmd.ie   = 1'b0;
        expect_csr("crmd after store", `CSR_CRMD, exp_crmd);
        expect_csr("prmd after store", `CSR_PRMD, exp_prmd);
    endtask

    task automatic set_ecode(input logic [6:0] code);
        trap.ecode_we = 1'b1;
        trap.ecode_in = code;
        next_cycle();
        trap.ecode_we = 1'b0;
    endtask

    // counts edges after a commit until ESTAT shows the timer bit
    task automatic wait_timer_int(input int edges_expected, input int edges_before);
        int          n;
        logic [31:0] v;
        n = edges_before;
        csr_read(`CSR_ESTAT, v);
        while (!v[TI_BIT] && n <= edges_expected + 8) begin
            next_cycle();
            n++;
            csr_read(`CSR_ESTAT, v);
        end
        if (!v[TI_BIT]) begin
            $display("timer interrupt never arrived after %0d cycles", n);
            errors++;
        end else begin
            check_word("timer interrupt delay", n, edges_expected);
        end
    endtask

    ////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////

    initial begin
        logic [31:0] d;
        logic [31:0] m;
        logic [31:0] v;
        logic [6:0]  code;
        clk = 1'b0;
        rstn = 1'b0;
        csr_wr = '0;
        raddr = '0;
        trap = '0;
        hw_int = '0;
        errors = 0;
        prop_errors = 0;
        cycles = 0;
        lfsr_state = 16'd60769;
        exp_crmd = '0;
        exp_crmd.da = 1'b1;
        exp_prmd = '0;
        exp_ecfg = '0;
        exp_era = '0;
        exp_eentry = '0;
        exp_ecode = '0;
        exp_esub = '0;
        exp_sw = '0;
        exp_ti = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rstn = 1'b1;

        expect_csr("crmd after reset", `CSR_CRMD, exp_crmd);
        expect_csr("prmd after reset", `CSR_PRMD, exp_prmd);
        check_word("int_cpu after reset", 32'(int_cpu), '0);
        check_word("int_idle after reset", 32'(int_idle), '0);

        for (int i = 0; i < RAND_ITERS; i++) begin
            rand_bits(32, d);
            rand_bits(32, m);
            csr_write(`CSR_ECFG, m, d);
            // lie bit 10 is reserved
            exp_ecfg = apply_mask(exp_ecfg, d, m) & 32'h0000_1bff;
            expect_csr("ecfg masked write", `CSR_ECFG, exp_ecfg);
            csr_write(`CSR_ERA, m, d);
            exp_era = apply_mask(exp_era, d, m);
            expect_csr("era masked write", `CSR_ERA, exp_era);
            csr_write(`CSR_EENTRY, m, d);
            exp_eentry = apply_mask(exp_eentry, d, m) & 32'hffff_ffc0;
            expect_csr("eentry masked write", `CSR_EENTRY, exp_eentry);
            check_word("status eentry", status.eentry, exp_eentry);
        end

        // illegal then legal then illegal translation pair
        crmd_write_check(32'h0000_01ff, 32'h0000_01f8);
        crmd_write_check(32'h0000_0018, 32'h0000_0010);
        crmd_write_check(32'h0000_0018, 32'h0000_0000);
        for (int i = 0; i < RAND_ITERS; i++) begin
            rand_bits(32, d);
            rand_bits(32, m);
            crmd_write_check(m, d);
        end

        // store and restore
        crmd_write_check(32'h0000_0007, 32'h0000_0007);
        do_store();
        expect_stored();
        do_restore();
        trap.store_state = 1'b1;
        csr_write(`CSR_CRMD, 32'h0000_0007, 32'h0000_0006);
        trap.store_state = 1'b0;
        expect_stored();
        do_restore();

        // two-level exception code
        for (int i = 0; i < 8; i++) begin
            rand_bits(7, v);
            code = (i == 0) ? 7'h40 : (i == 1) ? 7'h4a : v[6:0];
            set_ecode(code);
            exp_ecode = code[5:0];
            exp_esub = (code[5:0] != 6'd0) ? {8'b0, code[6]} : 9'b0;
            exp_is = {1'b0, exp_ti, 1'b0, hw_int, exp_sw};
            expect_csr("estat after set_ecode", `CSR_ESTAT,
                       estat_word(exp_ecode, exp_esub, exp_is));
            check_word("status ecode", 32'(status.ecode), 32'(exp_ecode));
        end
        rand_bits(32, d);
        rand_bits(32, v);
        trap.era_we = 1'b1;
        trap.era_in = d;
        csr_write(`CSR_ERA, 32'hffff_ffff, v);
        trap.era_we = 1'b0;
        exp_era = d;
        expect_csr("era hardware over software", `CSR_ERA, exp_era);
        check_word("status era", status.era, exp_era);

        // one-shot timer
        d = (32'(K_ONESHOT) << 2) | 32'h1;
        csr_write(`CSR_TCFG, 32'hffff_ffff, d);
        expect_csr("tcfg one-shot", `CSR_TCFG, d);
        wait_timer_int(4 * K_ONESHOT + 3, 0);
        exp_ti = 1'b1;
        expect_csr("tval after time-out", `CSR_TVAL, '0);
        repeat (3) next_cycle();
        expect_csr("tval parked at zero", `CSR_TVAL, '0);
        csr_write(`CSR_TICLR, 32'h1, 32'h1);
        exp_ti = 1'b0;
        exp_is = {1'b0, exp_ti, 1'b0, hw_int, exp_sw};
        expect_csr("estat after ticlr", `CSR_ESTAT, estat_word(exp_ecode, exp_esub, exp_is));

        // periodic timer
        csr_write(`CSR_TCFG, 32'hffff_ffff, (32'(K_PERIODIC) << 2) | 32'h3);
        wait_timer_int(4 * K_PERIODIC + 3, 0);
        csr_write(`CSR_TICLR, 32'h1, 32'h1);
        csr_read(`CSR_ESTAT, v);
        check_word("timer bit after ticlr", 32'(v[TI_BIT]), '0);
        wait_timer_int(4 * K_PERIODIC + 2, 1);
        exp_ti = 1'b1;
        csr_write(`CSR_TCFG, 32'hffff_ffff, '0);

        // interrupt pending outputs
        crmd_write_check(32'h0000_0004, 32'h0000_0004);
        for (int i = 0; i < IRQ_ITERS; i++) begin
            rand_bits(32, d);
            csr_write(`CSR_ECFG, 32'hffff_ffff, d);
            exp_ecfg = d & 32'h0000_1bff;
            rand_bits(2, v);
            csr_write(`CSR_ESTAT, 32'h3, v);
            exp_sw = v[1:0];
            rand_bits(8, v);
            hw_int = v[7:0];
            if (i == IRQ_ITERS / 2) begin
                csr_write(`CSR_TICLR, 32'h1, 32'h1);
                exp_ti = 1'b0;
            end
            if (i == IRQ_ITERS - 3) begin
                crmd_write_check(32'h0000_0004, 32'h0000_0000);
            end
            exp_is = {1'b0, exp_ti, 1'b0, hw_int, exp_sw};
            expect_csr("estat interrupt bits", `CSR_ESTAT,
                       estat_word(exp_ecode, exp_esub, exp_is));
            check_word("int_idle", 32'(int_idle), 32'(|exp_is));
            check_word("int_cpu", 32'(int_cpu), 32'(exp_crmd.ie & (|(exp_ecfg[12:0] & exp_is))));
        end

        $display("errors: %0d check, %0d property, %0d cycles", errors, prop_errors, cycles);
        if (errors == 0 && prop_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- hdl/csr_except_regs.sv
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_except_regs (
    input  logic                   clk,
    input  logic                   rstn,
    input  csr_pkg::csr_wr_t       csr_wr,
    input  csr_pkg::trap_evt_t     trap,
    input  logic [`HW_INT_W-1:0]   hw_int,
    input  logic                   timer_int,
    input  logic                   ie,
    output logic [`CSR_DATA_W-1:0] ecfg,
    output csr_pkg::estat_t        estat,
    output logic [`CSR_DATA_W-1:0] era,
    output logic [`CSR_DATA_W-1:0] eentry,
    output logic                   int_cpu,
    output logic                   int_idle
);

    logic                                 wr_ecfg;
    logic                                 wr_estat;
    logic                                 wr_era;
    logic                                 wr_eentry;
    logic [`LIE_W-1:0]                    lie;
    logic [`SW_INT_W-1:0]                 sw_int;
    logic [`SW_INT_W-1:0]                 sw_mask;
    logic [`ECODE_W-1:0]                  ecode;
    logic [`ESUBCODE_W-1:0]               esubcode;
    logic [`CSR_DATA_W-1:`EENTRY_LSB]     eentry_va;
    logic [`LIE_W-1:0]                    int_vec;
    logic [`CSR_DATA_W-1:0]               ecfg_nx;
    logic [`CSR_DATA_W-1:0]               eentry_nx;

    assign wr_ecfg   = csr_wr.en && (csr_wr.addr == `CSR_ECFG);
    assign wr_estat  = csr_wr.en && (csr_wr.addr == `CSR_ESTAT);
    assign wr_era    = csr_wr.en && (csr_wr.addr == `CSR_ERA);
    assign wr_eentry = csr_wr.en && (csr_wr.addr == `CSR_EENTRY);

    assign ecfg_nx   = csr_pkg::mask_merge(ecfg, csr_wr.data.raw, csr_wr.mask);
    assign eentry_nx = csr_pkg::mask_merge(eentry, csr_wr.data.raw, csr_wr.mask);
    assign sw_mask   = csr_wr.mask[`SW_INT_W-1:0];

    ////////////////////////////////////////
    // ecfg and estat
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lie <= '0;
        end else if (wr_ecfg) begin
            lie <= ecfg_nx[`LIE_W-1:0] & `ECFG_LIE_MASK;
        end
    end

    // hardware code update blocks the software int write
    always_ff @(posedge clk) begin
        if (!rstn) begin
            sw_int   <= '0;
            ecode    <= '0;
            esubcode <= '0;
        end else if (trap.ecode_we) begin
            ecode    <= trap.ecode_in[`ECODE_W-1:0];
            // interrupts carry no subcode
            esubcode <= (|trap.ecode_in[`ECODE_W-1:0]) ?
                        `ESUBCODE_W'(trap.ecode_in[`ECODE_W]) : '0;
        end else if (wr_estat) begin
            sw_int <= (sw_int & ~sw_mask)
                      | (csr_wr.data.estat.is[`SW_INT_W-1:0] & sw_mask);
        end
    end

    ////////////////////////////////////////
    // era and eentry
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            era <= '0;
        end else if (trap.era_we) begin
            era <= trap.era_in;
        end else if (wr_era) begin
            era <= csr_pkg::mask_merge(era, csr_wr.data.raw, csr_wr.mask);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            eentry_va <= '0;
        end else if (wr_eentry) begin
            eentry_va <= eentry_nx[`CSR_DATA_W-1:`EENTRY_LSB];
        end
    end

    // is: ipi, ti, reserved, hwi[7:0], swi[1:0]
    assign int_vec = {1'b0, timer_int, 1'b0, hw_int, sw_int};

    assign ecfg   = {{(`CSR_DATA_W-`LIE_W){1'b0}}, lie};
    assign eentry = {eentry_va, {`EENTRY_LSB{1'b0}}};
    assign estat  = '{
        pad_hi:   '0,
        esubcode: esubcode,
        ecode:    ecode,
        pad_lo:   '0,
        is:       int_vec
    };

    assign int_idle = |int_vec;
    assign int_cpu  = ie & (|(lie & int_vec));

endmodule

//--- hdl/csr_file.sv
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_file (
    input  logic                     clk,
    input  logic                     rstn,
    input  csr_pkg::csr_wr_t         csr_wr,
    input  logic [`CSR_ADDR_W-1:0]   raddr,
    output logic [`CSR_DATA_W-1:0]   rdata,
    input  csr_pkg::trap_evt_t       trap,
    input  logic [`HW_INT_W-1:0]     hw_int,
    output csr_pkg::cpu_status_t     status,
    output logic                     int_cpu,
    output logic                     int_idle
);

    csr_pkg::crmd_t          crmd;
    csr_pkg::prmd_t          prmd;
    csr_pkg::tcfg_t          tcfg;
    csr_pkg::estat_t         estat;
    logic [`CSR_DATA_W-1:0]  tval;
    logic [`CSR_DATA_W-1:0]  ecfg;
    logic [`CSR_DATA_W-1:0]  era;
    logic [`CSR_DATA_W-1:0]  eentry;
    logic                    timer_int;

    csr_mode_ctrl u_mode_ctrl (
        .clk    (clk),
        .rstn   (rstn),
        .csr_wr (csr_wr),
        .trap   (trap),
        .crmd   (crmd),
        .prmd   (prmd)
    );

    csr_timer u_timer (
        .clk       (clk),
        .rstn      (rstn),
        .csr_wr    (csr_wr),
        .tcfg      (tcfg),
        .tval      (tval),
        .timer_int (timer_int)
    );

    csr_except_regs u_except_regs (
        .clk       (clk),
        .rstn      (rstn),
        .csr_wr    (csr_wr),
        .trap      (trap),
        .hw_int    (hw_int),
        .timer_int (timer_int),
        .ie        (crmd.ie),
        .ecfg      (ecfg),
        .estat     (estat),
        .era       (era),
        .eentry    (eentry),
        .int_cpu   (int_cpu),
        .int_idle  (int_idle)
    );

    csr_read_mux u_read_mux (
        .raddr  (raddr),
        .crmd   (crmd),
        .prmd   (prmd),
        .ecfg   (ecfg),
        .estat  (estat),
        .era    (era),
        .eentry (eentry),
        .tcfg   (tcfg),
        .tval   (tval),
        .rdata  (rdata)
    );

    // translate_mode 01 direct, 10 paged
    assign status = '{
        plv:            crmd.plv,
        ie:             crmd.ie,
        translate_mode: {crmd.pg, crmd.da},
        datf:           crmd.datf,
        datm:           crmd.datm,
        ecode:          estat.ecode,
        era:            era,
        eentry:         eentry
    };

endmodule

//--- hdl/csr_mode_ctrl.sv
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_mode_ctrl (
    input  logic               clk,
    input  logic               rstn,
    input  csr_pkg::csr_wr_t   csr_wr,
    input  csr_pkg::trap_evt_t trap,
    output csr_pkg::crmd_t     crmd,
    output csr_pkg::prmd_t     prmd
);

    // direct address mode out of reset
    localparam csr_pkg::crmd_t CRMD_RST = '{
        zero: '0,
        datm: 2'b00,
        datf: 2'b00,
        pg:   1'b0,
        da:   1'b1,
        ie:   1'b0,
        plv:  2'b00
    };

    logic               wr_crmd;
    logic               wr_prmd;
    logic               pg_da_ok;
    csr_pkg::csr_word_u crmd_nx;
    csr_pkg::csr_word_u prmd_nx;

    assign wr_crmd = csr_wr.en && (csr_wr.addr == `CSR_CRMD);
    assign wr_prmd = csr_wr.en && (csr_wr.addr == `CSR_PRMD);

    assign crmd_nx.raw = csr_pkg::mask_merge(crmd, csr_wr.data.raw, csr_wr.mask);
    assign prmd_nx.raw = csr_pkg::mask_merge(prmd, csr_wr.data.raw, csr_wr.mask);

    // {pg,da} must stay one-hot
    assign pg_da_ok = crmd_nx.crmd.pg ^ crmd_nx.crmd.da;

    ////////////////////////////////////////
    // crmd: return > entry > software
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            crmd <= CRMD_RST;
        end else if (trap.restore_state) begin
            crmd.plv <= prmd.pplv;
            crmd.ie  <= prmd.pie;
        end else if (trap.store_state) begin
            // kernel entry
            crmd.plv <= 2'b00;
            crmd.ie  <= 1'b0;
        end else if (wr_crmd) begin
            crmd.plv  <= crmd_nx.crmd.plv;
            crmd.ie   <= crmd_nx.crmd.ie;
            crmd.datf <= crmd_nx.crmd.datf;
            crmd.datm <= crmd_nx.crmd.datm;
            if (pg_da_ok) begin
                crmd.pg <= crmd_nx.crmd.pg;
                crmd.da <= crmd_nx.crmd.da;
            end
        end
    end

    ////////////////////////////////////////
    // prmd: entry > software
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            prmd <= '0;
        end else if (trap.store_state) begin
            prmd.pplv <= crmd.plv;
            prmd.pie  <= crmd.ie;
        end else if (wr_prmd) begin
            prmd.pplv <= prmd_nx.prmd.pplv;
            prmd.pie  <= prmd_nx.prmd.pie;
        end
    end

endmodule

//--- hdl/csr_pkg.sv
`include "csr_defines.svh"

package csr_pkg;

    ////////////////////////////////////////
    // register layouts
    ////////////////////////////////////////

    typedef struct packed {
        logic [22:0] zero;
        logic [1:0]  datm;
        logic [1:0]  datf;
        logic        pg;
        logic        da;
        logic        ie;
        logic [1:0]  plv;
    } crmd_t;

    typedef struct packed {
        logic [28:0] zero;
        logic        pie;
        logic [1:0]  pplv;
    } prmd_t;

    typedef struct packed {
        logic [`CSR_DATA_W-`ESTAT_ECODE_LSB-`ECODE_W-`ESUBCODE_W-1:0] pad_hi;
        logic [`ESUBCODE_W-1:0]                                       esubcode;
        logic [`ECODE_W-1:0]                                          ecode;
        logic [`ESTAT_ECODE_LSB-`LIE_W-1:0]                           pad_lo;
        logic [`LIE_W-1:0]                                            is;
    } estat_t;

    typedef struct packed {
        logic [29:0] initval;
        logic        periodic;
        logic        en;
    } tcfg_t;

    typedef struct packed {
        logic [30:0] zero;
        logic        clr;
    } ticlr_t;

    // one write word, seen through each register's layout
    typedef union packed {
        logic [`CSR_DATA_W-1:0] raw;
        crmd_t                  crmd;
        prmd_t                  prmd;
        estat_t                 estat;
        tcfg_t                  tcfg;
        ticlr_t                 ticlr;
    } csr_word_u;

    ////////////////////////////////////////
    // ports
    ////////////////////////////////////////

    typedef struct packed {
        logic                   en;
        logic [`CSR_ADDR_W-1:0] addr;
        logic [`CSR_DATA_W-1:0] mask;
        csr_word_u              data;
    } csr_wr_t;

    // ecode_in[5:0] primary code, ecode_in[6] subcode
    typedef struct packed {
        logic                   store_state;
        logic                   restore_state;
        logic                   ecode_we;
        logic [`ECODE_W:0]      ecode_in;
        logic                   era_we;
        logic [`CSR_DATA_W-1:0] era_in;
    } trap_evt_t;

    typedef struct packed {
        logic [1:0]             plv;
        logic                   ie;
        logic [1:0]             translate_mode;
        logic [1:0]             datf;
        logic [1:0]             datm;
        logic [`ECODE_W-1:0]    ecode;
        logic [`CSR_DATA_W-1:0] era;
        logic [`CSR_DATA_W-1:0] eentry;
    } cpu_status_t;

    // per-bit write: mask 1 takes the new bit
    function automatic logic [`CSR_DATA_W-1:0] mask_merge(
        input logic [`CSR_DATA_W-1:0] old_word,
        input logic [`CSR_DATA_W-1:0] new_word,
        input logic [`CSR_DATA_W-1:0] mask
    );
        return (old_word & ~mask) | (new_word & mask);
    endfunction

endpackage

//--- hdl/csr_read_mux.sv
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_read_mux (
    input  logic [`CSR_ADDR_W-1:0] raddr,
    input  csr_pkg::crmd_t         crmd,
    input  csr_pkg::prmd_t         prmd,
    input  logic [`CSR_DATA_W-1:0] ecfg,
    input  csr_pkg::estat_t        estat,
    input  logic [`CSR_DATA_W-1:0] era,
    input  logic [`CSR_DATA_W-1:0] eentry,
    input  csr_pkg::tcfg_t         tcfg,
    input  logic [`CSR_DATA_W-1:0] tval,
    output logic [`CSR_DATA_W-1:0] rdata
);

    always_comb begin
        case (raddr)
            `CSR_CRMD: begin
                rdata = crmd;
            end
            `CSR_PRMD: begin
                rdata = prmd;
            end
            `CSR_ECFG: begin
                rdata = ecfg;
            end
            `CSR_ESTAT: begin
                rdata = estat;
            end
            `CSR_ERA: begin
                rdata = era;
            end
            `CSR_EENTRY: begin
                rdata = eentry;
            end
            `CSR_TCFG: begin
                rdata = tcfg;
            end
            `CSR_TVAL: begin
                rdata = tval;
            end
            // write-only ticlr falls through to zero
            default: begin
                rdata = '0;
            end
        endcase
    end

endmodule

//--- hdl/csr_timer.sv
`timescale 1ns/1ps
`include "csr_defines.svh"

module csr_timer (
    input  logic                   clk,
    input  logic                   rstn,
    input  csr_pkg::csr_wr_t       csr_wr,
    output csr_pkg::tcfg_t         tcfg,
    output logic [`CSR_DATA_W-1:0] tval,
    output logic                   timer_int
);

    logic               wr_tcfg;
    logic               clr_req;
    logic               just_set;
    logic               time_out;
    csr_pkg::csr_word_u tcfg_nx;

    assign wr_tcfg = csr_wr.en && (csr_wr.addr == `CSR_TCFG);

    assign clr_req = csr_wr.en && (csr_wr.addr == `CSR_TICLR)
                     && csr_wr.mask[`TICLR_CLR] && csr_wr.data.ticlr.clr;

    assign tcfg_nx.raw = csr_pkg::mask_merge(tcfg, csr_wr.data.raw, csr_wr.mask);

    ////////////////////////////////////////
    // configuration
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            tcfg <= '0;
        end else if (wr_tcfg) begin
            tcfg <= tcfg_nx.tcfg;
        end
    end

    // any tcfg write restarts the count
    always_ff @(posedge clk) begin
        if (!rstn) begin
            just_set <= 1'b0;
        end else begin
            just_set <= wr_tcfg && (|csr_wr.mask);
        end
    end

    ////////////////////////////////////////
    // down-counter
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            tval     <= '0;
            time_out <= 1'b0;
        end else if (just_set || (tval == '0)) begin
            time_out <= 1'b0;
            // one-shot mode parks at zero
            if (just_set || tcfg.periodic) begin
                tval <= {tcfg.initval, `TVAL_TAIL};
            end
        end else if (tcfg.en) begin
            tval     <= tval - 1'b1;
            time_out <= (tval == 1);
        end
    end

    // clear beats a set in the same cycle
    always_ff @(posedge clk) begin
        if (!rstn || clr_req) begin
            timer_int <= 1'b0;
        end else if (time_out) begin
            timer_int <= 1'b1;
        end
    end

endmodule

//--- include/csr_defines.svh
`ifndef CSR_DEFINES_SVH
`define CSR_DEFINES_SVH

////////////////////////////////////////
// bus widths
////////////////////////////////////////

`define CSR_ADDR_W       14
`define CSR_DATA_W       32

////////////////////////////////////////
// csr addresses
////////////////////////////////////////

`define CSR_CRMD         14'h000
`define CSR_PRMD         14'h001
`define CSR_ECFG         14'h004
`define CSR_ESTAT        14'h005
`define CSR_ERA          14'h006
`define CSR_EENTRY       14'h00c
`define CSR_TCFG         14'h041
`define CSR_TVAL         14'h042
`define CSR_TICLR        14'h044

////////////////////////////////////////
// field positions and widths
////////////////////////////////////////

`define ECODE_W          6
`define ESUBCODE_W       9
`define ESTAT_ECODE_LSB  16
`define SW_INT_W         2
`define HW_INT_W         8
`define LIE_W            13

// lie bit 10 is reserved in la32r
`define ECFG_LIE_MASK    13'h1bff

`define EENTRY_LSB       6
`define TICLR_CLR        0

// low bits appended on tval load
`define TVAL_TAIL        2'b01

`endif

//--- run.sh
#!/usr/bin/env bash
# build and run the csr_file testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module csr_file_tb -f csr_file.f -o csr_file_sim; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/csr_file_sim)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

# pass only when the testbench printed its pass line
if grep -qx "sim passed" <<< "$sim_out"; then
    exit 0
fi
exit 1
